//--- common/cpuPkg.sv
package cpuPkg;

	// ------------------------------------------------------------
	// ALU functions
	// ------------------------------------------------------------
	typedef enum logic [3:0] {
		aluPassB,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluInc,
		aluDec
	} aluFuncT;

	// ------------------------------------------------------------
	// bus source selects
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		idbPcl,
		idbPch,
		idbSb,
		idbDir,
		idbA,
		idbP
	} idbSelT;

	typedef enum logic [2:0] {
		sbIdb,
		sbA,
		sbX,
		sbY,
		sbSp,
		sbAor
	} sbSelT;

	typedef enum logic [1:0] {
		adlPcl,
		adlDir,
		adlAor,
		adlVec
	} adlSelT;

	typedef enum logic [1:0] {
		adhPch,
		adhDir,
		adhZp,
		adhVec
	} adhSelT;

	// ALU B input from the internal data bus or the address low bus
	localparam logic aluBIdb = 1'b0;
	localparam logic aluBAdl = 1'b1;

	// test readback selection
	typedef enum logic [2:0] {
		regA,
		regX,
		regY,
		regSp,
		regP,
		regPcl,
		regPch
	} regSelT;

	// ------------------------------------------------------------
	// opcodes of the supported subset
	// ------------------------------------------------------------
	localparam logic [7:0] opLdaImm = 8'hA9;
	localparam logic [7:0] opLdxImm = 8'hA2;
	localparam logic [7:0] opLdyImm = 8'hA0;
	localparam logic [7:0] opAdcImm = 8'h69;
	localparam logic [7:0] opSbcImm = 8'hE9;
	localparam logic [7:0] opAndImm = 8'h29;
	localparam logic [7:0] opOraImm = 8'h09;
	localparam logic [7:0] opEorImm = 8'h49;
	localparam logic [7:0] opStaZp  = 8'h85;
	localparam logic [7:0] opTax    = 8'hAA;
	localparam logic [7:0] opTxa    = 8'h8A;
	localparam logic [7:0] opInx    = 8'hE8;
	localparam logic [7:0] opDex    = 8'hCA;
	localparam logic [7:0] opJmpAbs = 8'h4C;
	localparam logic [7:0] opClc    = 8'h18;
	localparam logic [7:0] opSec    = 8'h38;
	localparam logic [7:0] opNop    = 8'hEA;

	// status register bit positions
	localparam int flagC = 0;
	localparam int flagZ = 1;
	localparam int flagV = 6;
	localparam int flagN = 7;

	// unused bit 5 and interrupt disable set after reset
	localparam logic [7:0] pReset = 8'h24;

	localparam logic [15:0] resetVector = 16'hFFFC;

endpackage

//--- verilog/cpuAlu.sv
`timescale 1ns/1ps

module cpuAlu (
	input  cpuPkg::aluFuncT func,
	input  logic            carryIn,
	input  logic [7:0]      a,
	input  logic [7:0]      b,
	output logic [7:0]      result,
	output logic            cout,
	output logic            vout,
	output logic            zout,
	output logic            nout
);

	logic [7:0] bOp;
	logic [8:0] sum;
	logic arith;

	// subtract is A + ~B + C, carry set means no borrow
	assign bOp   = (func == cpuPkg::aluSub) ? ~b : b;
	assign sum   = {1'b0, a} + {1'b0, bOp} + {8'h00, carryIn};
	assign arith = (func == cpuPkg::aluAdd) || (func == cpuPkg::aluSub);

	always_comb begin
		case (func)
			cpuPkg::aluAdd,
			cpuPkg::aluSub: result = sum[7:0];
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr:  result = a | b;
			cpuPkg::aluXor: result = a ^ b;
			cpuPkg::aluInc: result = a + 8'd1;
			cpuPkg::aluDec: result = a - 8'd1;
			default:        result = b;
		endcase
	end

	assign cout = arith & sum[8];

	// operands of equal sign giving a result of the other sign
	assign vout = arith & (a[7] == bOp[7]) & (sum[7] != a[7]);

	assign zout = (result == 8'h00);
	assign nout = result[7];

endmodule

//--- verilog/regBank.sv
`timescale 1ns/1ps

module regBank (
	input  logic           clk,
	input  logic           arstN,
	input  logic           stall,
	input  logic [7:0]     sb,
	input  logic           aEn,
	input  logic           xEn,
	input  logic           yEn,
	input  logic           spEn,
	output logic [7:0]     a,
	output logic [7:0]     x,
	output logic [7:0]     y,
	output logic [7:0]     sp,
	input  cpuPkg::regSelT testSel,
	input  logic [7:0]     p,
	input  logic [7:0]     pcl,
	input  logic [7:0]     pch,
	output logic [7:0]     testValue
);

	// programmer registers, all written from the special bus
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			a  <= 8'h00;
			x  <= 8'h00;
			y  <= 8'h00;
			sp <= 8'hFF;
		end else if (!stall) begin
			if (aEn) a <= sb;
			if (xEn) x <= sb;
			if (yEn) y <= sb;
			if (spEn) sp <= sb;
		end
	end

	// test readback
	always_comb begin
		case (testSel)
			cpuPkg::regA:   testValue = a;
			cpuPkg::regX:   testValue = x;
			cpuPkg::regY:   testValue = y;
			cpuPkg::regSp:  testValue = sp;
			cpuPkg::regP:   testValue = p;
			cpuPkg::regPcl: testValue = pcl;
			cpuPkg::regPch: testValue = pch;
			default:        testValue = 8'h00;
		endcase
	end

endmodule

//--- verilog/addressUnit.sv
`timescale 1ns/1ps

module addressUnit (
	input  logic           clk,
	input  logic           arstN,
	input  logic           stall,
	input  cpuPkg::adlSelT adlSel,
	input  cpuPkg::adhSelT adhSel,
	input  logic [7:0]     dir,
	input  logic [7:0]     aor,
	input  logic           pcEn,
	input  logic           pcInc,
	input  logic           bufEn,
	output logic [7:0]     adl,
	output logic [7:0]     adh,
	output logic [7:0]     pcl,
	output logic [7:0]     pch,
	output logic [15:0]    addr
);

	logic [15:0] pc;
	logic [15:0] addrBuf;

	// ------------------------------------------------------------
	// address low and high buses
	// ------------------------------------------------------------
	always_comb begin
		case (adlSel)
			cpuPkg::adlDir: adl = dir;
			cpuPkg::adlAor: adl = aor;
			cpuPkg::adlVec: adl = cpuPkg::resetVector[7:0];
			default:        adl = pcl;
		endcase
	end

	always_comb begin
		case (adhSel)
			cpuPkg::adhDir: adh = dir;
			cpuPkg::adhZp:  adh = 8'h00;
			cpuPkg::adhVec: adh = cpuPkg::resetVector[15:8];
			default:        adh = pch;
		endcase
	end

	// ------------------------------------------------------------
	// program counter
	// ------------------------------------------------------------
	// a load with pcInc set leaves PC pointing past the fetched byte
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= cpuPkg::resetVector;
		end else if (!stall) begin
			if (pcEn) begin
				pc <= {adh, adl} + {15'd0, pcInc};
			end else if (pcInc) begin
				pc <= pc + 16'd1;
			end
		end
	end

	assign pcl = pc[7:0];
	assign pch = pc[15:8];

	// buffer keeps the last address, starts at the reset vector
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			addrBuf <= cpuPkg::resetVector;
		end else if (!stall && bufEn) begin
			addrBuf <= {adh, adl};
		end
	end

	assign addr = bufEn ? {adh, adl} : addrBuf;

endmodule

//--- control/cpuControl.sv
`timescale 1ns/1ps

module cpuControl (
	input  logic            clk,
	input  logic            arstN,
	input  logic            stall,
	input  logic [7:0]      dir,
	input  logic [7:0]      idb,
	input  logic            aluC,
	input  logic            aluV,
	input  logic            aluZ,
	input  logic            aluN,
	output cpuPkg::idbSelT  idbSel,
	output cpuPkg::sbSelT   sbSel,
	output cpuPkg::adlSelT  adlSel,
	output cpuPkg::adhSelT  adhSel,
	output cpuPkg::aluFuncT aluFunc,
	output logic            aluBSel,
	output logic            carryIn,
	output logic            aEn,
	output logic            xEn,
	output logic            yEn,
	output logic            spEn,
	output logic            pcEn,
	output logic            pcInc,
	output logic            aorEn,
	output logic            dirEn,
	output logic            bufEn,
	output logic            rnw,
	output logic            sync,
	output logic [7:0]      p
);

	// vector fetch, then T0 opcode fetch, T1 operand, T2 for STA and JMP
	typedef enum logic [2:0] {cycVec0, cycVec1, cycT0, cycT1, cycT2} cycleT;

	cycleT cycle;
	logic [7:0] ir;
	logic jumpNext;
	logic needT2;

	// the new opcode sits in DIR during T1, IR takes it at the end of T1
	assign needT2 = (dir == cpuPkg::opStaZp) || (dir == cpuPkg::opJmpAbs);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cycle    <= cycVec0;
			ir       <= cpuPkg::opNop;
			jumpNext <= 1'b0;
		end else if (!stall) begin
			case (cycle)
				cycVec0: cycle <= cycVec1;
				cycT0:   cycle <= cycT1;
				cycT1:   cycle <= needT2 ? cycT2 : cycT0;
				default: cycle <= cycT0;
			endcase
			if (cycle == cycT1) begin
				ir <= dir;
			end
			// next fetch goes to {DIR, AOR}
			jumpNext <= (cycle == cycVec1) || (cycle == cycT2 && ir == cpuPkg::opJmpAbs);
		end
	end

	// ------------------------------------------------------------
	// status register updated as the previous instruction completes in T0
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			p <= cpuPkg::pReset;
		end else if (!stall && cycle == cycT0) begin
			case (ir)
				cpuPkg::opLdaImm, cpuPkg::opLdxImm, cpuPkg::opLdyImm,
				cpuPkg::opTax, cpuPkg::opTxa: begin
					p[cpuPkg::flagN] <= idb[7];
					p[cpuPkg::flagZ] <= (idb == 8'h00);
				end
				cpuPkg::opAndImm, cpuPkg::opOraImm, cpuPkg::opEorImm,
				cpuPkg::opInx, cpuPkg::opDex: begin
					p[cpuPkg::flagN] <= aluN;
					p[cpuPkg::flagZ] <= aluZ;
				end
				cpuPkg::opAdcImm, cpuPkg::opSbcImm: begin
					p[cpuPkg::flagN] <= aluN;
					p[cpuPkg::flagZ] <= aluZ;
					p[cpuPkg::flagC] <= aluC;
					p[cpuPkg::flagV] <= aluV;
				end
				cpuPkg::opClc: p[cpuPkg::flagC] <= 1'b0;
				cpuPkg::opSec: p[cpuPkg::flagC] <= 1'b1;
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------
	// decode of cycle and opcode into selects and enables
	// ------------------------------------------------------------
	always_comb begin
		idbSel  = cpuPkg::idbDir;
		sbSel   = cpuPkg::sbA;
		adlSel  = cpuPkg::adlPcl;
		adhSel  = cpuPkg::adhPch;
		aluFunc = cpuPkg::aluPassB;
		aluBSel = cpuPkg::aluBAdl;
		carryIn = p[cpuPkg::flagC];
		aEn     = 1'b0;
		xEn     = 1'b0;
		yEn     = 1'b0;
		spEn    = 1'b0;
		pcEn    = 1'b0;
		pcInc   = 1'b0;
		aorEn   = 1'b0;
		dirEn   = 1'b0;
		bufEn   = 1'b1;
		rnw     = 1'b1;
		sync    = 1'b0;
		case (cycle)
			cycVec0: begin
				// address comes from the buffer, PC becomes vector + 1
				bufEn  = 1'b0;
				adlSel = cpuPkg::adlVec;
				adhSel = cpuPkg::adhVec;
				pcEn   = 1'b1;
				pcInc  = 1'b1;
				dirEn  = 1'b1;
			end
			cycVec1: begin
				dirEn   = 1'b1;
				aluBSel = cpuPkg::aluBIdb;
				aorEn   = 1'b1;
			end
			cycT0: begin
				sync  = 1'b1;
				dirEn = 1'b1;
				pcEn  = 1'b1;
				pcInc = 1'b1;
				if (jumpNext) begin
					adlSel = cpuPkg::adlAor;
					adhSel = cpuPkg::adhDir;
				end
				case (ir)
					cpuPkg::opLdaImm: begin
						sbSel = cpuPkg::sbIdb;
						aEn   = 1'b1;
					end
					cpuPkg::opLdxImm: begin
						sbSel = cpuPkg::sbIdb;
						xEn   = 1'b1;
					end
					cpuPkg::opLdyImm: begin
						sbSel = cpuPkg::sbIdb;
						yEn   = 1'b1;
					end
					cpuPkg::opTax: begin
						idbSel = cpuPkg::idbSb;
						xEn    = 1'b1;
					end
					cpuPkg::opTxa: begin
						sbSel  = cpuPkg::sbX;
						idbSel = cpuPkg::idbSb;
						aEn    = 1'b1;
					end
					cpuPkg::opAdcImm, cpuPkg::opSbcImm,
					cpuPkg::opAndImm, cpuPkg::opOraImm, cpuPkg::opEorImm: begin
						aluBSel = cpuPkg::aluBIdb;
						aorEn   = 1'b1;
						case (ir)
							cpuPkg::opAdcImm: aluFunc = cpuPkg::aluAdd;
							cpuPkg::opSbcImm: aluFunc = cpuPkg::aluSub;
							cpuPkg::opAndImm: aluFunc = cpuPkg::aluAnd;
							cpuPkg::opOraImm: aluFunc = cpuPkg::aluOr;
							default:          aluFunc = cpuPkg::aluXor;
						endcase
					end
					cpuPkg::opInx, cpuPkg::opDex: begin
						sbSel   = cpuPkg::sbX;
						aluFunc = (ir == cpuPkg::opInx) ? cpuPkg::aluInc : cpuPkg::aluDec;
						aorEn   = 1'b1;
					end
					default: ;
				endcase
			end
			cycT1: begin
				dirEn = 1'b1;
				// ALU results of the previous instruction land here
				case (ir)
					cpuPkg::opAdcImm, cpuPkg::opSbcImm,
					cpuPkg::opAndImm, cpuPkg::opOraImm, cpuPkg::opEorImm: begin
						sbSel = cpuPkg::sbAor;
						aEn   = 1'b1;
					end
					cpuPkg::opInx, cpuPkg::opDex: begin
						sbSel = cpuPkg::sbAor;
						xEn   = 1'b1;
					end
					default: ;
				endcase
				// step past the operand byte; implied opcodes do a dummy read
				case (dir)
					cpuPkg::opLdaImm, cpuPkg::opLdxImm, cpuPkg::opLdyImm,
					cpuPkg::opAdcImm, cpuPkg::opSbcImm, cpuPkg::opAndImm,
					cpuPkg::opOraImm, cpuPkg::opEorImm,
					cpuPkg::opStaZp, cpuPkg::opJmpAbs: pcInc = 1'b1;
					default: ;
				endcase
			end
			default: begin
				if (ir == cpuPkg::opStaZp) begin
					adlSel = cpuPkg::adlDir;
					adhSel = cpuPkg::adhZp;
					idbSel = cpuPkg::idbA;
					rnw    = 1'b0;
				end else begin
					// jump low byte to AOR while the high byte is read
					dirEn   = 1'b1;
					aluBSel = cpuPkg::aluBIdb;
					aorEn   = 1'b1;
				end
			end
		endcase
	end

endmodule

//--- verilog/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input  logic           clk,
	input  logic           arstN,
	input  logic           ready,
	input  logic [7:0]     dataIn,
	output logic [15:0]    addr,
	output logic [7:0]     dataOut,
	output logic           rnw,
	output logic           sync,
	input  cpuPkg::regSelT testSel,
	output logic [7:0]     testValue
);

	logic stall;
	logic [7:0] dirReg;
	logic [7:0] aorReg;
	logic [7:0] idb;
	logic [7:0] sb;
	logic [7:0] aluB;
	logic [7:0] aluOut;
	logic aluC, aluV, aluZ, aluN;

	cpuPkg::idbSelT idbSel;
	cpuPkg::sbSelT sbSel;
	cpuPkg::adlSelT adlSel;
	cpuPkg::adhSelT adhSel;
	cpuPkg::aluFuncT aluFunc;
	logic aluBSel, carryIn;
	logic aEn, xEn, yEn, spEn;
	logic pcEn, pcInc, aorEn, dirEn, bufEn;

	logic [7:0] p, a, x, y, sp;
	logic [7:0] adl, pcl, pch;

	// whole core holds while the memory is not ready
	assign stall = ~ready;

	// ------------------------------------------------------------
	// data input and ALU output registers
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!stall && dirEn) begin
			dirReg <= dataIn;
		end
		if (!stall && aorEn) begin
			aorReg <= aluOut;
		end
	end

	// ------------------------------------------------------------
	// internal buses
	// ------------------------------------------------------------
	always_comb begin
		case (idbSel)
			cpuPkg::idbPcl: idb = pcl;
			cpuPkg::idbPch: idb = pch;
			cpuPkg::idbSb:  idb = sb;
			cpuPkg::idbA:   idb = a;
			cpuPkg::idbP:   idb = p;
			default:        idb = dirReg;
		endcase
	end

	always_comb begin
		case (sbSel)
			cpuPkg::sbIdb: sb = idb;
			cpuPkg::sbX:   sb = x;
			cpuPkg::sbY:   sb = y;
			cpuPkg::sbSp:  sb = sp;
			cpuPkg::sbAor: sb = aorReg;
			default:       sb = a;
		endcase
	end

	assign aluB = (aluBSel == cpuPkg::aluBAdl) ? adl : idb;

	// stores put the internal data bus on the pins
	assign dataOut = idb;

	cpuControl control_i (
		.clk(clk), .arstN(arstN), .stall(stall),
		.dir(dirReg), .idb(idb),
		.aluC(aluC), .aluV(aluV), .aluZ(aluZ), .aluN(aluN),
		.idbSel(idbSel), .sbSel(sbSel), .adlSel(adlSel), .adhSel(adhSel),
		.aluFunc(aluFunc), .aluBSel(aluBSel), .carryIn(carryIn),
		.aEn(aEn), .xEn(xEn), .yEn(yEn), .spEn(spEn),
		.pcEn(pcEn), .pcInc(pcInc), .aorEn(aorEn), .dirEn(dirEn), .bufEn(bufEn),
		.rnw(rnw), .sync(sync), .p(p)
	);

	cpuAlu alu_i (
		.func(aluFunc), .carryIn(carryIn), .a(sb), .b(aluB),
		.result(aluOut), .cout(aluC), .vout(aluV), .zout(aluZ), .nout(aluN)
	);

	regBank regBank_i (
		.clk(clk), .arstN(arstN), .stall(stall), .sb(sb),
		.aEn(aEn), .xEn(xEn), .yEn(yEn), .spEn(spEn),
		.a(a), .x(x), .y(y), .sp(sp),
		.testSel(testSel), .p(p), .pcl(pcl), .pch(pch), .testValue(testValue)
	);

	addressUnit addressUnit_i (
		.clk(clk), .arstN(arstN), .stall(stall),
		.adlSel(adlSel), .adhSel(adhSel), .dir(dirReg), .aor(aorReg),
		.pcEn(pcEn), .pcInc(pcInc), .bufEn(bufEn),
		.adl(adl), .adh(), .pcl(pcl), .pch(pch), .addr(addr)
	);

endmodule

//--- verif/cpuTb_sva.sv
`timescale 1ns/1ps

module busProtocolChecks (
	input logic        clk,
	input logic        arstN,
	input logic        ready,
	input logic [15:0] addr,
	input logic [7:0]  dataOut,
	input logic        rnw,
	input logic        sync
);

	// reset leaves the bus in a read cycle
	readDuringReset: assert property (@(posedge clk) !arstN |=> rnw)
		else $error("rnw low during reset");

	// ------------------------------------------------------------
	// bus holds while the memory is not ready
	// ------------------------------------------------------------
	holdOnStall: assert property (@(posedge clk) disable iff (!arstN)
		!ready |=> $stable(addr) && $stable(rnw) && $stable(dataOut))
		else $error("bus changed during a ready-low cycle");

	noSyncOnWrite: assert property (@(posedge clk) disable iff (!arstN) sync |-> rnw)
		else $error("sync high on a write cycle");

endmodule

bind cpuTop busProtocolChecks busChecks_i (
	.clk(clk),
	.arstN(arstN),
	.ready(ready),
	.addr(addr),
	.dataOut(dataOut),
	.rnw(rnw),
	.sync(sync)
);

//--- verif/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

	localparam int patternDepth = 128;

	logic clk;
	logic arstN;
	logic ready;
	logic [7:0] dataIn;
	logic [15:0] addr;
	logic [7:0] dataOut;
	logic rnw;
	logic sync;
	cpuPkg::regSelT testSel;
	logic [7:0] testValue;

	// kind, address or selection, byte count, three data bytes
	logic [55:0] patterns [0:patternDepth-1];
	logic [7:0] mem [0:65535];
	logic [15:0] expWriteAddr [$];
	logic [7:0] expWriteData [$];
	cpuPkg::regSelT expRegSel [$];
	logic [7:0] expRegVal [$];
	int progBytes = 0;
	int errorCount = 0;
	logic [31:0] lcgState;

	cpuTop dut_i (
		.clk(clk), .arstN(arstN), .ready(ready), .dataIn(dataIn),
		.addr(addr), .dataOut(dataOut), .rnw(rnw), .sync(sync),
		.testSel(testSel), .testValue(testValue)
	);

	always #5 clk = ~clk;

	// memory answers within the same cycle
	assign dataIn = mem[addr];

	// ------------------------------------------------------------
	// failure reporting and compare tasks
	// ------------------------------------------------------------
	task automatic abortRun();
		errorCount++;
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkAddr(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkData(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkReg(input cpuPkg::regSelT sel, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t testValue[%s] got %h expected %h", $time, sel.name(), got, exp);
			abortRun();
		end
	endtask

	// ------------------------------------------------------------
	// stall generator
	// ------------------------------------------------------------
	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// about one cycle in four is stalled
	function automatic logic nextReady(input bit withStalls);
		if (!withStalls) begin
			return 1'b1;
		end
		lcgState = lcgStep(lcgState);
		return lcgState[31:30] != 2'b00;
	endfunction

	// ------------------------------------------------------------
	// pattern file and memory image
	// ------------------------------------------------------------
	task automatic loadPatterns();
		logic [55:0] rec;
		for (int i = 0; i < patternDepth; i++) begin
			patterns[i] = '0;
		end
		$readmemh("verif/cpuPatterns.hex", patterns);
		for (int i = 0; i < patternDepth; i++) begin
			rec = patterns[i];
			case (rec[55:48])
				8'h01: progBytes += rec[31:24];
				8'h02: begin
					expWriteAddr.push_back(rec[47:32]);
					expWriteData.push_back(rec[23:16]);
				end
				8'h03: begin
					expRegSel.push_back(cpuPkg::regSelT'(rec[34:32]));
					expRegVal.push_back(rec[23:16]);
				end
				default: ;
			endcase
		end
		if (progBytes == 0) begin
			$display("no program bytes were found in verif/cpuPatterns.hex");
			abortRun();
		end
	endtask

	task automatic loadMemory();
		logic [55:0] rec;
		logic [15:0] base;
		// background differs in both address bytes
		for (int i = 0; i < 65536; i++) begin
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
		end
		for (int i = 0; i < patternDepth; i++) begin
			rec = patterns[i];
			if (rec[55:48] == 8'h01) begin
				base = rec[47:32];
				for (int j = 0; j < rec[31:24]; j++) begin
					mem[base + 16'(j)] = rec[23 - 8*j -: 8];
				end
			end
		end
	endtask

	// ------------------------------------------------------------
	// one program run from reset to the final loop
	// ------------------------------------------------------------
	task automatic runProgram(input bit withStalls);
		int busCycle;
		int writeIdx;
		bit finished;
		bit haveFetch;
		bit wrPending;
		logic [15:0] lastFetch;
		logic [15:0] vector;
		logic [15:0] wrAddr;
		logic [7:0] wrData;
		busCycle = 0;
		writeIdx = 0;
		finished = 1'b0;
		haveFetch = 1'b0;
		loadMemory();
		vector = {mem[cpuPkg::resetVector + 16'd1], mem[cpuPkg::resetVector]};

		@(posedge clk);
		arstN <= 1'b0;
		ready <= 1'b1;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;
		ready <= nextReady(withStalls);

		while (!finished) begin
			@(negedge clk);
			wrPending = 1'b0;
			if (ready) begin
				// vector reads come first, then the fetch at the vector
				if (busCycle < 2) begin
					checkAddr("addr", addr, cpuPkg::resetVector + 16'(busCycle));
				end
				if (busCycle == 2 && !sync) begin
					$display("the cycle after the vector reads is not an opcode fetch");
					abortRun();
				end else if (busCycle == 2) begin
					checkAddr("addr", addr, vector);
				end
				if (!rnw && writeIdx >= expWriteAddr.size()) begin
					$display("a write to %h came after all expected writes", addr);
					abortRun();
				end else if (!rnw) begin
					checkAddr("addr", addr, expWriteAddr[writeIdx]);
					checkData("dataOut", dataOut, expWriteData[writeIdx]);
					writeIdx++;
					wrPending = 1'b1;
					wrAddr = addr;
					wrData = dataOut;
				end
				// two fetches in a row from one address is the closing JMP loop
				if (sync) begin
					if (haveFetch && addr == lastFetch) begin
						finished = 1'b1;
					end
					haveFetch = 1'b1;
					lastFetch = addr;
				end
				busCycle++;
			end
			@(posedge clk);
			if (wrPending) begin
				mem[wrAddr] <= wrData;
			end
			// ready stays low after the loop so the readback sees a frozen core
			ready <= finished ? 1'b0 : nextReady(withStalls);
		end

		if (writeIdx != expWriteAddr.size()) begin
			$display("only %0d of %0d expected writes were seen", writeIdx, expWriteAddr.size());
			abortRun();
		end
		for (int i = 0; i < expRegSel.size(); i++) begin
			@(posedge clk);
			testSel <= expRegSel[i];
			@(negedge clk);
			checkReg(expRegSel[i], testValue, expRegVal[i]);
		end
	endtask

	// two runs, each bounded by three cycles per byte and four times that for stalls
	initial begin : watchdog
		int limitCycles;
		wait (progBytes != 0);
		limitCycles = 2 * (progBytes * 3 * 4 + 100);
		repeat (limitCycles) @(posedge clk);
		$display("the program did not reach its final loop within %0d cycles", limitCycles);
		abortRun();
	end

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		ready = 1'b1;
		testSel = cpuPkg::regA;
		lcgState = 32'h5fc2_38d4;
		loadPatterns();
		runProgram(1'b0);
		runProgram(1'b1);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- verif/cpuPatterns.hex
// columns: kind(2) addr(4) count(2) byte0(2) byte1(2) byte2(2), one record per line
// kind 01 memory bytes, 02 expected write (data in byte0), 03 readback (addr = selection)
01FFFC02000200  // reset vector 0200
01020002A93700  // LDA #$37
01020201180000  // CLC
01020302694A00  // ADC #$4A   A=81 C=0 V=1
01020502851000  // STA $10
01020701380000  // SEC
01020802E99000  // SBC #$90   A=F1 C=0 V=0
01020A02851100  // STA $11
01020C02293C00  // AND #$3C   A=30
01020E0209C100  // ORA #$C1   A=F1
0102100249F100  // EOR #$F1   A=00 Z=1
01021202851200  // STA $12
01021402A2FF00  // LDX #$FF
01021601E80000  // INX        X=00
01021701E80000  // INX        X=01
01021801CA0000  // DEX        X=00
01021901CA0000  // DEX        X=FF
01021A018A0000  // TXA        A=FF
01021B02851300  // STA $13
01021D02A08000  // LDY #$80
01021F02A90500  // LDA #$05
01022101AA0000  // TAX        X=05
01022201EA0000  // NOP
010223034C3002  // JMP $0230
01022602A9EE00  // LDA #$EE, skipped by the jump
01022802851F00  // STA $1F, skipped by the jump
01023001380000  // SEC
01023102697F00  // ADC #$7F   A=85 C=0 V=1
01023302851400  // STA $14
01023501180000  // CLC
01023602699000  // ADC #$90   A=15 C=1 V=1
01023802851500  // STA $15
01023A034C3A02  // JMP $023A  final loop
02001001810000  // write 0010 = 81
02001101F10000  // write 0011 = F1
02001201000000  // write 0012 = 00
02001301FF0000  // write 0013 = FF
02001401850000  // write 0014 = 85
02001501150000  // write 0015 = 15
03000001150000  // A
03000101050000  // X
03000201800000  // Y
03000301FF0000  // SP
03000401650000  // P with N=0 V=1 Z=0 C=1
030005013B0000  // PCL, one past the loop opcode
03000601020000  // PCH

//--- filelist.f
common/cpuPkg.sv
verilog/cpuAlu.sv
verilog/regBank.sv
verilog/addressUnit.sv
control/cpuControl.sv
verilog/cpuTop.sv
verif/cpuTb_sva.sv
verif/cpuTb.sv

//--- Bender.yml
package:
  name: cpu6502

sources:
  - common/cpuPkg.sv
  - verilog/cpuAlu.sv
  - verilog/regBank.sv
  - verilog/addressUnit.sv
  - control/cpuControl.sv
  - verilog/cpuTop.sv
  - target: test
    files:
      - verif/cpuTb_sva.sv
      - verif/cpuTb.sv
